/* Makefile */
TOP = writeback_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f src.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f src.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -F -q "Simulation passed"

clean:
	rm -rf obj_dir

/* design/commit_router.sv */
`timescale 1ns/1ps

module commit_router import wb_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   commit_if.sink    held,
   input  logic      dec_wb_valid,
   input  reg_num_t  dec_wb_reg,
   input  gpr_data_t dec_wb_data,
   input  op_size_t  dec_wb_size,
   reg_write_if.source regs,
   mem_write_if.source mem
);

   logic is_xchg;
   logic same_reg;
   logic use_port2;
   logic xchg_mem;
   logic needs_mem;
   logic dec_ok;
   logic mem_ok;
   logic retire;

   assign is_xchg = (held.alu_op == ALU_XCHG);

   // xchg of a register with itself writes only the low half
   assign same_reg  = held.op_a_is_reg && (held.op_b_reg == held.dest_reg);
   assign use_port2 = is_xchg && held.op_b_is_reg && !same_reg;

   // memory second operand takes the partner value
   assign xchg_mem  = is_xchg && held.op_b_is_address;
   assign needs_mem = held.op_a_is_address || xchg_mem;

   // decode owns port 1 this cycle
   // hold off too when decode hits the port 2 register
   assign dec_ok = !dec_wb_valid
                   || (!held.op_a_is_reg && !(use_port2 && dec_wb_reg == held.op_b_reg));
   assign mem_ok = !needs_mem || mem.ready;

   assign held.ready = dec_ok && mem_ok;
   assign retire     = held.valid && held.ready;

   // decode wins port 1
   always_comb begin
      if (dec_wb_valid) begin
         regs.en      = 1'b1;
         regs.reg_num = dec_wb_reg;
         regs.size    = dec_wb_size;
         regs.data    = dec_wb_data;
      end else begin
         regs.en      = retire && held.op_a_is_reg;
         regs.reg_num = held.dest_reg;
         regs.size    = held.opsize;
         regs.data    = held.result[DATA_W-1:0];
      end
   end

   // port 2 carries the exchange partner
   assign regs.en_2      = retire && use_port2;
   assign regs.reg_num_2 = held.op_b_reg;
   assign regs.data_2    = held.result[RESULT_W-1:DATA_W];

   assign mem.valid   = retire && needs_mem;
   assign mem.address = xchg_mem ? held.op_b_address : held.dest_address;
   assign mem.data    = xchg_mem ? {{(RESULT_W-DATA_W){1'b0}}, held.result[RESULT_W-1:DATA_W]}
                                 : held.result;
   assign mem.size    = held.opsize;

   // an accepted request must leave the port occupied
   a_mem_handoff: assert property (@(posedge clk) disable iff (rst)
      mem.valid |=> !mem.ready);

endmodule

/* design/gpr_file.sv */
`timescale 1ns/1ps

module gpr_file import wb_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   reg_write_if.sink regs,
   input  reg_num_t  rd_reg_a,
   output gpr_data_t rd_data_a,
   input  reg_num_t  rd_reg_b,
   output gpr_data_t rd_data_b
);

   gpr_data_t gpr_q [NUM_REGS];
   gpr_data_t merged;

   // sized write keeps the untouched upper bits
   always_comb begin
      merged = gpr_q[regs.reg_num];
      case (regs.size)
         size_byte: begin
            merged[7:0] = regs.data[7:0];
         end
         size_word: begin
            merged[15:0] = regs.data[15:0];
         end
         default: begin
            merged = regs.data;
         end
      endcase
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         for (int i = 0; i < NUM_REGS; i++) begin
            gpr_q[i] <= '0;
         end
      end else begin
         if (regs.en) begin
            gpr_q[regs.reg_num] <= merged;
         end
         // exchange partner, always full width
         if (regs.en_2) begin
            gpr_q[regs.reg_num_2] <= regs.data_2;
         end
      end
   end

   // combinational reads
   assign rd_data_a = gpr_q[rd_reg_a];
   assign rd_data_b = gpr_q[rd_reg_b];

   // the router keeps the two ports apart
   a_no_dual_target: assert property (@(posedge clk) disable iff (rst)
      !(regs.en && regs.en_2 && regs.reg_num == regs.reg_num_2));

endmodule

/* design/mem_write_port.sv */
`timescale 1ns/1ps

module mem_write_port import wb_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   mem_write_if.sink mem,
   output logic      wmem_valid,
   input  logic      wmem_ready,
   output mem_addr_t wmem_address,
   output result_t   wmem_wr_data,
   output op_size_t  wmem_wr_size
);

   logic full;

   // takes a new request only when empty
   assign mem.ready = !full;

   always_ff @(posedge clk) begin
      if (rst) begin
         full <= 1'b0;
      end else if (mem.valid && mem.ready) begin
         full <= 1'b1;
      end else if (wmem_ready) begin
         full <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (mem.valid && mem.ready) begin
         wmem_address <= mem.address;
         wmem_wr_data <= mem.data;
         wmem_wr_size <= mem.size;
      end
   end

   assign wmem_valid = full;

   a_wmem_stable: assert property (@(posedge clk) disable iff (rst)
      wmem_valid && !wmem_ready |=> wmem_valid && $stable(wmem_address)
         && $stable(wmem_wr_data) && $stable(wmem_wr_size));

endmodule

/* design/result_intake.sv */
`timescale 1ns/1ps

module result_intake import wb_pkg::*; (
   input  logic      clk,
   input  logic      rst,
   input  logic      ex_valid,
   output logic      ex_ready,
   input  reg_num_t  ex_dest_reg,
   input  mem_addr_t ex_dest_address,
   input  result_t   ex_result,
   input  op_size_t  ex_opsize,
   input  alu_op_t   ex_alu_op,
   input  logic      ex_op_a_is_reg,
   input  logic      ex_op_a_is_address,
   input  reg_num_t  ex_op_b_reg,
   input  mem_addr_t ex_op_b_address,
   input  logic      ex_op_b_is_reg,
   input  logic      ex_op_b_is_address,
   commit_if.source  held
);

   logic full;
   logic load;

   // slot frees in the same cycle it drains
   assign ex_ready = !full || held.ready;
   assign load     = ex_valid && ex_ready;

   always_ff @(posedge clk) begin
      if (rst) begin
         full <= 1'b0;
      end else if (load) begin
         full <= 1'b1;
      end else if (held.ready) begin
         full <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         held.dest_reg        <= ex_dest_reg;
         held.dest_address    <= ex_dest_address;
         held.result          <= ex_result;
         held.opsize          <= ex_opsize;
         held.alu_op          <= ex_alu_op;
         held.op_a_is_reg     <= ex_op_a_is_reg;
         held.op_a_is_address <= ex_op_a_is_address;
         held.op_b_reg        <= ex_op_b_reg;
         held.op_b_address    <= ex_op_b_address;
         held.op_b_is_reg     <= ex_op_b_is_reg;
         held.op_b_is_address <= ex_op_b_is_address;
      end
   end

   assign held.valid = full;

   // router may stall for several cycles, entry must not move meanwhile
   a_held_stable: assert property (@(posedge clk) disable iff (rst)
      held.valid && !held.ready |=> held.valid && $stable(held.result)
         && $stable(held.dest_reg) && $stable(held.dest_address)
         && $stable(held.opsize) && $stable(held.alu_op)
         && $stable(held.op_b_reg) && $stable(held.op_b_address));

endmodule

/* design/wb_ifs.sv */
`timescale 1ns/1ps

// held execute result, intake to router
interface commit_if import wb_pkg::*; ();
   logic      valid;
   logic      ready;
   reg_num_t  dest_reg;
   mem_addr_t dest_address;
   result_t   result;
   op_size_t  opsize;
   alu_op_t   alu_op;
   logic      op_a_is_reg;
   logic      op_a_is_address;
   reg_num_t  op_b_reg;
   mem_addr_t op_b_address;
   logic      op_b_is_reg;
   logic      op_b_is_address;

   modport source (
      output valid, dest_reg, dest_address, result, opsize, alu_op,
      output op_a_is_reg, op_a_is_address, op_b_reg, op_b_address,
      output op_b_is_reg, op_b_is_address,
      input  ready
   );

   modport sink (
      input  valid, dest_reg, dest_address, result, opsize, alu_op,
      input  op_a_is_reg, op_a_is_address, op_b_reg, op_b_address,
      input  op_b_is_reg, op_b_is_address,
      output ready
   );
endinterface

// register file writes, no handshake
interface reg_write_if import wb_pkg::*; ();
   logic      en;
   reg_num_t  reg_num;
   op_size_t  size;
   gpr_data_t data;
   logic      en_2;
   reg_num_t  reg_num_2;
   gpr_data_t data_2;

   modport source (output en, reg_num, size, data, en_2, reg_num_2, data_2);
   modport sink (input en, reg_num, size, data, en_2, reg_num_2, data_2);
endinterface

// memory write requests, router to port
interface mem_write_if import wb_pkg::*; ();
   logic      valid;
   logic      ready;
   mem_addr_t address;
   result_t   data;
   op_size_t  size;

   modport source (output valid, address, data, size, input ready);
   modport sink (input valid, address, data, size, output ready);
endinterface

/* design/wb_pkg.sv */
package wb_pkg;

   // datapath widths
   localparam int DATA_W   = 32;
   localparam int RESULT_W = 64;
   localparam int ADDR_W   = 32;

   // eax, ecx, edx, ebx, esp, ebp, esi, edi
   localparam int NUM_REGS = 8;
   localparam int REG_NUM_W = $clog2(NUM_REGS);

   typedef logic [REG_NUM_W-1:0] reg_num_t;
   typedef logic [DATA_W-1:0]    gpr_data_t;

   // low half is the first result, high half the exchange partner
   typedef logic [RESULT_W-1:0]  result_t;
   typedef logic [ADDR_W-1:0]    mem_addr_t;

   // operand size as it reaches writeback
   typedef enum logic [1:0] {
      size_byte  = 2'd0,
      size_word  = 2'd1,
      size_dword = 2'd2
   } op_size_t;

   typedef logic [3:0] alu_op_t;

   // exchange needs a second register or memory write
   localparam alu_op_t ALU_XCHG = 4'd14;

endpackage

/* design/writeback_top.sv */
`timescale 1ns/1ps

module writeback_top import wb_pkg::*; (
   input  logic      clk,
   input  logic      rst,

   // execute results
   input  logic      ex_valid,
   output logic      ex_ready,
   input  reg_num_t  ex_dest_reg,
   input  mem_addr_t ex_dest_address,
   input  result_t   ex_result,
   input  op_size_t  ex_opsize,
   input  alu_op_t   ex_alu_op,
   input  logic      ex_op_a_is_reg,
   input  logic      ex_op_a_is_address,
   input  reg_num_t  ex_op_b_reg,
   input  mem_addr_t ex_op_b_address,
   input  logic      ex_op_b_is_reg,
   input  logic      ex_op_b_is_address,

   // direct register write from decode
   input  logic      dec_wb_valid,
   input  reg_num_t  dec_wb_reg,
   input  gpr_data_t dec_wb_data,
   input  op_size_t  dec_wb_size,

   // operand read
   input  reg_num_t  rd_reg_a,
   output gpr_data_t rd_data_a,
   input  reg_num_t  rd_reg_b,
   output gpr_data_t rd_data_b,

   // data memory write port
   output logic      wmem_valid,
   input  logic      wmem_ready,
   output mem_addr_t wmem_address,
   output result_t   wmem_wr_data,
   output op_size_t  wmem_wr_size,

   output logic      busy
);

   commit_if    held_if ();
   reg_write_if regs_if ();
   mem_write_if mem_if ();

   result_intake result_intake_i (
      .clk                (clk),
      .rst                (rst),
      .ex_valid           (ex_valid),
      .ex_ready           (ex_ready),
      .ex_dest_reg        (ex_dest_reg),
      .ex_dest_address    (ex_dest_address),
      .ex_result          (ex_result),
      .ex_opsize          (ex_opsize),
      .ex_alu_op          (ex_alu_op),
      .ex_op_a_is_reg     (ex_op_a_is_reg),
      .ex_op_a_is_address (ex_op_a_is_address),
      .ex_op_b_reg        (ex_op_b_reg),
      .ex_op_b_address    (ex_op_b_address),
      .ex_op_b_is_reg     (ex_op_b_is_reg),
      .ex_op_b_is_address (ex_op_b_is_address),
      .held               (held_if.source)
   );

   commit_router commit_router_i (
      .clk          (clk),
      .rst          (rst),
      .held         (held_if.sink),
      .dec_wb_valid (dec_wb_valid),
      .dec_wb_reg   (dec_wb_reg),
      .dec_wb_data  (dec_wb_data),
      .dec_wb_size  (dec_wb_size),
      .regs         (regs_if.source),
      .mem          (mem_if.source)
   );

   gpr_file gpr_file_i (
      .clk       (clk),
      .rst       (rst),
      .regs      (regs_if.sink),
      .rd_reg_a  (rd_reg_a),
      .rd_data_a (rd_data_a),
      .rd_reg_b  (rd_reg_b),
      .rd_data_b (rd_data_b)
   );

   mem_write_port mem_write_port_i (
      .clk          (clk),
      .rst          (rst),
      .mem          (mem_if.sink),
      .wmem_valid   (wmem_valid),
      .wmem_ready   (wmem_ready),
      .wmem_address (wmem_address),
      .wmem_wr_data (wmem_wr_data),
      .wmem_wr_size (wmem_wr_size)
   );

   // result waiting in the slot or write still pending
   assign busy = held_if.valid || wmem_valid;

endmodule

/* dv/writeback_tb.sv */
`timescale 1ns/1ps

module writeback_tb import wb_pkg::*; ();

   localparam int HANDSHAKE_TIMEOUT = 200;
   localparam int DRAIN_TIMEOUT     = 2000;

   typedef struct packed {
      reg_num_t  dest_reg;
      mem_addr_t dest_address;
      result_t   result;
      op_size_t  opsize;
      alu_op_t   alu_op;
      logic      a_is_reg;
      logic      a_is_addr;
      reg_num_t  b_reg;
      mem_addr_t b_addr;
      logic      b_is_reg;
      logic      b_is_addr;
   } ex_item_t;

   logic      clk = 1'b0;
   logic      rst;
   logic      ex_valid;
   logic      ex_ready;
   ex_item_t  ex_item;
   logic      dec_wb_valid;
   reg_num_t  dec_wb_reg;
   gpr_data_t dec_wb_data;
   op_size_t  dec_wb_size;
   reg_num_t  rd_reg_a;
   gpr_data_t rd_data_a;
   reg_num_t  rd_reg_b;
   gpr_data_t rd_data_b;
   logic      wmem_valid;
   logic      wmem_ready = 1'b0;
   mem_addr_t wmem_address;
   result_t   wmem_wr_data;
   op_size_t  wmem_wr_size;
   logic      busy;

   integer    seed = 32'h1e5e_59c2;
   int        ready_level = 4;
   int        full_stalls = 0;
   int        issued_mem = 0;
   int        observed_mem = 0;
   int        compared_mem = 0;
   gpr_data_t model_regs [NUM_REGS];

   // expected and observed memory writes in commit order
   mem_addr_t exp_addr_q[$];
   result_t   exp_data_q[$];
   op_size_t  exp_size_q[$];
   mem_addr_t obs_addr_q[$];
   result_t   obs_data_q[$];
   op_size_t  obs_size_q[$];

   // responder state for the stall check
   logic      was_stalled = 1'b0;
   mem_addr_t last_addr;
   result_t   last_data;
   op_size_t  last_size;

   writeback_top writeback_top_i (
      .clk                (clk),
      .rst                (rst),
      .ex_valid           (ex_valid),
      .ex_ready           (ex_ready),
      .ex_dest_reg        (ex_item.dest_reg),
      .ex_dest_address    (ex_item.dest_address),
      .ex_result          (ex_item.result),
      .ex_opsize          (ex_item.opsize),
      .ex_alu_op          (ex_item.alu_op),
      .ex_op_a_is_reg     (ex_item.a_is_reg),
      .ex_op_a_is_address (ex_item.a_is_addr),
      .ex_op_b_reg        (ex_item.b_reg),
      .ex_op_b_address    (ex_item.b_addr),
      .ex_op_b_is_reg     (ex_item.b_is_reg),
      .ex_op_b_is_address (ex_item.b_is_addr),
      .dec_wb_valid       (dec_wb_valid),
      .dec_wb_reg         (dec_wb_reg),
      .dec_wb_data        (dec_wb_data),
      .dec_wb_size        (dec_wb_size),
      .rd_reg_a           (rd_reg_a),
      .rd_data_a          (rd_data_a),
      .rd_reg_b           (rd_reg_b),
      .rd_data_b          (rd_data_b),
      .wmem_valid         (wmem_valid),
      .wmem_ready         (wmem_ready),
      .wmem_address       (wmem_address),
      .wmem_wr_data       (wmem_wr_data),
      .wmem_wr_size       (wmem_wr_size),
      .busy               (busy)
   );

   always #10 clk = ~clk;

   task automatic abort_run(string why);
      $display("%0t: %s", $time, why);
      $display("Simulation failed");
      $fatal(1, "run aborted");
   endtask

   task automatic check_flag(logic got, logic exp, string what);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
         $display("Simulation failed");
         $fatal(1, "flag mismatch");
      end
   endtask

   task automatic check_reg(reg_num_t r, gpr_data_t got, gpr_data_t exp);
      if (got !== exp) begin
         $display("[ERROR] %0t: register %0d reads %h, expected %h", $time, r, got, exp);
         $display("Simulation failed");
         $fatal(1, "register mismatch");
      end
   endtask

   task automatic check_mem(mem_addr_t got_a, mem_addr_t exp_a, result_t got_d,
                            result_t exp_d, op_size_t got_s, op_size_t exp_s);
      if (got_a !== exp_a || got_d !== exp_d || got_s !== exp_s) begin
         $display("[ERROR] %0t: memory write %h/%h/%0d, expected %h/%h/%0d", $time,
                  got_a, got_d, got_s, exp_a, exp_d, exp_s);
         $display("Simulation failed");
         $fatal(1, "memory write mismatch");
      end
   endtask

   function automatic logic [31:0] next_random();
      next_random = $random(seed);
   endfunction

   function automatic reg_num_t random_reg();
      logic [31:0] r;
      r = next_random();
      random_reg = r[2:0];
   endfunction

   function automatic op_size_t pick_size(logic [31:0] r);
      case (r[1:0])
         2'd0: pick_size = size_byte;
         2'd1: pick_size = size_word;
         default: pick_size = size_dword;
      endcase
   endfunction

   // x86 sized write changes only the low byte or word
   function automatic gpr_data_t merge_reg(gpr_data_t old_value, gpr_data_t data, op_size_t size);
      case (size)
         size_byte: merge_reg = {old_value[31:8], data[7:0]};
         size_word: merge_reg = {old_value[31:16], data[15:0]};
         default: merge_reg = data;
      endcase
   endfunction

   // returns 1 when the entry stores to memory
   function automatic logic expect_mem(input ex_item_t it, output mem_addr_t addr,
                                       output result_t data);
      addr = it.dest_address;
      data = it.result;
      if (it.alu_op == ALU_XCHG && it.b_is_addr) begin
         addr = it.b_addr;
         data = {32'h0, it.result[63:32]};
         expect_mem = 1'b1;
      end else begin
         expect_mem = it.a_is_addr;
      end
   endfunction

   task automatic apply_model(ex_item_t it);
      mem_addr_t addr;
      result_t   data;
      if (it.a_is_reg) begin
         model_regs[it.dest_reg] = merge_reg(model_regs[it.dest_reg], it.result[31:0], it.opsize);
      end
      // partner register only when it differs from the first operand
      if (it.alu_op == ALU_XCHG && it.b_is_reg && !(it.a_is_reg && it.b_reg == it.dest_reg)) begin
         model_regs[it.b_reg] = it.result[63:32];
      end
      if (expect_mem(it, addr, data)) begin
         exp_addr_q.push_back(addr);
         exp_data_q.push_back(data);
         exp_size_q.push_back(it.opsize);
         issued_mem++;
      end
   endtask

   function automatic ex_item_t base_item(reg_num_t dest);
      ex_item_t    it;
      logic [31:0] r;
      it = '0;
      r = next_random();
      it.dest_reg = dest;
      it.result = {next_random(), next_random()};
      it.opsize = pick_size(next_random());
      it.alu_op = (r[3:0] == ALU_XCHG) ? 4'd0 : r[3:0];
      base_item = it;
   endfunction

   // runs from 2 ns after an edge to 2 ns after the accepting edge
   task automatic send_result(ex_item_t it);
      int waited;
      ex_item = it;
      ex_valid = 1'b1;
      apply_model(it);
      waited = 0;
      do begin
         @(posedge clk);
         waited++;
         if (!ex_ready) full_stalls++;
         if (waited > HANDSHAKE_TIMEOUT) abort_run("execute result never accepted by the stage");
      end while (!ex_ready);
      #2;
      ex_valid = 1'b0;
   endtask

   task automatic dec_write(reg_num_t r, gpr_data_t d, op_size_t s);
      dec_wb_reg = r;
      dec_wb_data = d;
      dec_wb_size = s;
      dec_wb_valid = 1'b1;
      model_regs[r] = merge_reg(model_regs[r], d, s);
      @(posedge clk);
      #2;
      dec_wb_valid = 1'b0;
   endtask

   task automatic wait_idle(string what);
      int waited;
      waited = 0;
      while (busy) begin
         @(posedge clk);
         waited++;
         if (waited > DRAIN_TIMEOUT) abort_run({"busy stuck high after ", what});
      end
      repeat (2) @(posedge clk);
      #2;
   endtask

   task automatic check_all_regs();
      for (int i = 0; i < NUM_REGS; i++) begin
         rd_reg_a = reg_num_t'(i);
         rd_reg_b = reg_num_t'(NUM_REGS - 1 - i);
         #1;
         check_reg(rd_reg_a, rd_data_a, model_regs[i]);
         check_reg(rd_reg_b, rd_data_b, model_regs[NUM_REGS - 1 - i]);
      end
      // back to 2 ns after an edge for the next stimulus
      @(posedge clk);
      #2;
   endtask

   // ready_level of 4 keeps memory always ready
   always @(posedge clk) begin
      #2;
      wmem_ready = (next_random() % 4) < ready_level;
   end

   always @(posedge clk) begin
      if (!rst) begin
         if (was_stalled) begin
            check_flag(wmem_valid, 1'b1, "wmem_valid while stalled");
            check_mem(wmem_address, last_addr, wmem_wr_data, last_data, wmem_wr_size, last_size);
         end
         if (wmem_valid && wmem_ready) begin
            obs_addr_q.push_back(wmem_address);
            obs_data_q.push_back(wmem_wr_data);
            obs_size_q.push_back(wmem_wr_size);
            observed_mem++;
         end
         was_stalled = wmem_valid && !wmem_ready;
         last_addr = wmem_address;
         last_data = wmem_wr_data;
         last_size = wmem_wr_size;
      end
   end

   // in-order compare of completed writes
   always @(negedge clk) begin
      while (compared_mem < obs_addr_q.size()) begin
         if (compared_mem >= exp_addr_q.size()) abort_run("memory write seen with none expected");
         check_mem(obs_addr_q[compared_mem], exp_addr_q[compared_mem],
                   obs_data_q[compared_mem], exp_data_q[compared_mem],
                   obs_size_q[compared_mem], exp_size_q[compared_mem]);
         compared_mem++;
      end
   end

   initial begin
      ex_item_t it;
      rst = 1'b1;
      ex_valid = 1'b0;
      ex_item = '0;
      dec_wb_valid = 1'b0;
      dec_wb_reg = '0;
      dec_wb_data = '0;
      dec_wb_size = size_byte;
      rd_reg_a = '0;
      rd_reg_b = '0;
      for (int i = 0; i < NUM_REGS; i++) model_regs[i] = '0;
      repeat (16) @(posedge clk);
      #2;
      rst = 1'b0;

      // reset state
      #1;
      check_flag(wmem_valid, 1'b0, "wmem_valid after reset");
      check_flag(ex_ready, 1'b1, "ex_ready after reset");
      check_flag(busy, 1'b0, "busy after reset");
      check_all_regs();

      // back-to-back sized register writes
      for (int i = 0; i < 40; i++) begin
         it = base_item(random_reg());
         it.a_is_reg = 1'b1;
         send_result(it);
      end
      wait_idle("sized register writes");
      check_all_regs();

      // decode alone and then against execute traffic on eax..ebx
      for (int i = 0; i < 4; i++) dec_write(random_reg(), next_random(), pick_size(next_random()));
      fork
         begin
            for (int i = 0; i < 12; i++) begin
               it = base_item(random_reg() & 3'b011);
               it.a_is_reg = 1'b1;
               send_result(it);
            end
         end
         begin
            for (int i = 0; i < 8; i++) begin
               dec_write(random_reg() | 3'b100, next_random(), pick_size(next_random()));
               if (i % 2 == 1) begin
                  @(posedge clk);
                  #2;
               end
            end
         end
      join
      wait_idle("decode writes");
      check_all_regs();

      // xchg ecx with ebx, edx with memory, ebp with itself
      it = base_item(3'd1);
      it.alu_op = ALU_XCHG;
      it.opsize = size_dword;
      it.a_is_reg = 1'b1;
      it.b_reg = 3'd3;
      it.b_is_reg = 1'b1;
      send_result(it);
      it = base_item(3'd2);
      it.alu_op = ALU_XCHG;
      it.a_is_reg = 1'b1;
      it.b_addr = next_random();
      it.b_is_addr = 1'b1;
      send_result(it);
      it = base_item(3'd5);
      it.alu_op = ALU_XCHG;
      it.opsize = size_word;
      it.a_is_reg = 1'b1;
      it.b_reg = 3'd5;
      it.b_is_reg = 1'b1;
      send_result(it);
      wait_idle("exchange cases");
      check_all_regs();

      // stores and memory exchanges under back-pressure
      ready_level = 1;
      full_stalls = 0;
      for (int i = 0; i < 30; i++) begin
         it = base_item(random_reg());
         if (next_random() % 3 == 0) begin
            it.alu_op = ALU_XCHG;
            it.a_is_reg = 1'b1;
            it.b_addr = next_random();
            it.b_is_addr = 1'b1;
         end else begin
            it.dest_address = next_random();
            it.a_is_addr = 1'b1;
         end
         send_result(it);
      end
      if (full_stalls == 0) abort_run("ex_ready never dropped under memory back-pressure");
      wait_idle("memory traffic");
      check_all_regs();

      if (issued_mem == observed_mem && compared_mem == issued_mem) begin
         $display("Simulation passed");
         $finish;
      end else begin
         $display("[ERROR] %0t: issued %0d memory writes, observed %0d, compared %0d",
                  $time, issued_mem, observed_mem, compared_mem);
         $display("Simulation failed");
         $fatal(1, "memory write count mismatch");
      end
   end

endmodule

/* src.f */
design/wb_pkg.sv
design/wb_ifs.sv
design/result_intake.sv
design/commit_router.sv
design/gpr_file.sv
design/mem_write_port.sv
design/writeback_top.sv
dv/writeback_tb.sv
